//--- build.f
+incdir+tb
common/z90_pkg.sv
core/z90_alu16.sv
core/z90_xregs.sv
core/z90_mode_stack.sv
core/z90_sequencer.sv
core/z90_core.sv
tb/z90_core_tb.sv

//--- Bender.yml
package:
  name: z90_core

sources:
  - common/z90_pkg.sv
  - core/z90_alu16.sv
  - core/z90_xregs.sv
  - core/z90_mode_stack.sv
  - core/z90_sequencer.sv
  - core/z90_core.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/z90_core_tb.sv

//--- tb/z90_tb_model.svh
// Testbench model helpers for the Z90 core
// LFSR, reference ALU, program assembly and the value check
`ifndef Z90_TB_MODEL_SVH
`define Z90_TB_MODEL_SVH

logic [31:0] lfsr_q = 32'h1ca7;
addr_t       asm_pc;
int          prog_bytes;

// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
function automatic logic [15:0] rand_bits(input int n);
  logic [15:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    r      = {r[14:0], fb};
  end
  return r;
endfunction

// Expected page 0 ALU result modulo 2^16
function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
  case (op)
    ALU_ADD: return a + b;
    ALU_SUB: return a - b;
    ALU_AND: return a & b;
    ALU_OR:  return a | b;
    ALU_XOR: return a ^ b;
    default: return 16'h0000;
  endcase
endfunction

// ----------------------------------------
// Program assembly
// ----------------------------------------
task automatic emit(input byte_t b);
  mem[asm_pc] = b;
  asm_pc++;
  prog_bytes++;
endtask

task automatic page0(input logic [3:0] major, input xidx_t rd,
                     input logic [3:0] sub, input xidx_t rs);
  emit(OP_ESCAPE);
  emit(PAGE0_PREFIX);
  emit({major, rd});
  emit({sub, rs});
endtask

task automatic page1(input logic [3:0] major, input xidx_t rd,
                     input xidx_t base, input xidx_t idx, input byte_t disp);
  emit(OP_ESCAPE);
  emit(PAGE1_PREFIX);
  emit({major, rd});
  emit({base, idx});
  emit(disp);
endtask

// Return PC is the address after the entry PC bytes
task automatic modeup(input byte_t target, input addr_t entry);
  page0(P0_MAJOR_SYS, 4'd0, SUB_MODEUP, 4'd0);
  emit(target);
  emit(entry[7:0]);
  emit(entry[15:8]);
endtask

task automatic put_word(input addr_t addr, input word_t w);
  mem[addr]         = w[7:0];
  mem[addr + 16'd1] = w[15:8];
endtask

// Low byte first
task automatic expect_word(input addr_t addr, input word_t w);
  exp_addr.push_back(addr);
  exp_data.push_back(w[7:0]);
  exp_addr.push_back(addr + 16'd1);
  exp_data.push_back(w[15:8]);
endtask

task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
  if (got !== exp) begin
    errors++;
    $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
  end
endtask

`endif

//--- tb/z90_core_tb.sv
// Z90 core testbench
// Clock and reset, memory model with random delays, scenarios
// Write checker, timeout and summary
`timescale 1ns/1ps

module z90_core_tb;
  import z90_pkg::*;

  localparam addr_t ERR_ADDR        = 16'hFFE0;
  localparam int    CYCLES_PER_BYTE = 16;

  logic   clk;
  logic   rst_n         = 1'b0;
  logic   mem_req;
  logic   mem_req_ready = 1'b0;
  addr_t  mem_addr;
  logic   mem_we;
  byte_t  mem_wdata;
  logic   mem_rsp_valid = 1'b0;
  byte_t  mem_rdata     = 8'h00;
  logic   mem_rsp_err   = 1'b0;
  logic   halted;
  logic   trap;
  cause_t trap_cause;
  addr_t  trap_pc;
  byte_t  tier;

  byte_t mem [65536];
  int    errors = 0;
  addr_t exp_addr [$];
  byte_t exp_data [$];
  byte_t tier_seen [$];
  byte_t last_tier;
  int    run_cycles  = 0;
  int    cycle_limit = 1000;

  logic       busy;
  logic [1:0] wait_cnt;
  addr_t      lat_addr;
  logic       lat_we;
  byte_t      lat_wdata;

  `include "z90_tb_model.svh"

  z90_core DUT (
    .clk, .rst_n,
    .mem_req, .mem_req_ready, .mem_addr, .mem_we, .mem_wdata,
    .mem_rsp_valid, .mem_rdata, .mem_rsp_err,
    .halted, .trap, .trap_cause, .trap_pc, .tier
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) run_cycles <= run_cycles + 1;

  // ----------------------------------------
  // Memory model with ready and response delays of 0 to 3 cycles
  // ----------------------------------------
  always @(posedge clk) begin
    mem_rsp_valid <= 1'b0;
    if (!rst_n) begin
      mem_req_ready <= 1'b0;
      mem_rsp_err   <= 1'b0;
      busy          <= 1'b0;
      wait_cnt      <= 2'd0;
    end else if (mem_req_ready) begin
      // Request accepted on this edge
      mem_req_ready <= 1'b0;
      busy          <= 1'b1;
      wait_cnt      <= 2'(rand_bits(2));
      lat_addr      <= mem_addr;
      lat_we        <= mem_we;
      lat_wdata     <= mem_wdata;
    end else if (busy) begin
      if (wait_cnt == 2'd0) begin
        mem_rsp_valid <= 1'b1;
        mem_rsp_err   <= (lat_addr == ERR_ADDR);
        mem_rdata     <= mem[lat_addr];
        if (lat_we) mem[lat_addr] <= lat_wdata;
        busy          <= 1'b0;
        wait_cnt      <= 2'(rand_bits(2));
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end else if (mem_req) begin
      if (wait_cnt == 2'd0) mem_req_ready <= 1'b1;
      else wait_cnt <= wait_cnt - 2'd1;
    end
  end

  // Write checker, halted bus monitor and tier trace
  always @(posedge clk) begin
    if (rst_n) begin
      if (mem_req && mem_req_ready && mem_we) begin
        if (exp_addr.size() == 0) begin
          errors++;
          $display("Unexpected write of %h to address %h at %0t ns", mem_wdata, mem_addr, $time);
        end else begin
          compare("mem_addr", mem_addr, exp_addr.pop_front());
          compare("mem_wdata", mem_wdata, exp_data.pop_front());
        end
      end
      if (halted && mem_req) begin
        errors++;
        $display("Bus request issued while the core is halted at %0t ns", $time);
      end
      if (tier !== last_tier) begin
        tier_seen.push_back(tier);
        last_tier = tier;
      end
    end else begin
      last_tier = TIER_RESET;
    end
  end

  initial begin
    wait (run_cycles >= cycle_limit);
    errors++;
    $display("Timeout: core did not halt within %0d cycles", run_cycles);
    finish_run();
  end

  task automatic finish_run();
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  // ----------------------------------------
  // Scenario control
  // ----------------------------------------
  task automatic begin_program();
    @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = byte_t'(i[7:0] ^ {i[11:8], i[15:12]} ^ 8'h5a);
    end
    asm_pc     = '0;
    prog_bytes = 0;
    exp_addr.delete();
    exp_data.delete();
    tier_seen.delete();
  endtask

  task automatic run_program(input logic exp_trap, input cause_t exp_cause,
                             input addr_t exp_pc);
    cycle_limit = run_cycles + 8 + prog_bytes * CYCLES_PER_BYTE + 200;
    repeat (8) @(posedge clk);
    compare("mem_req", mem_req, 1'b0);
    compare("halted", halted, 1'b0);
    compare("trap", trap, 1'b0);
    compare("tier", tier, TIER_RESET);
    rst_n <= 1'b1;
    while (halted !== 1'b1) @(posedge clk);
    repeat (10) @(posedge clk);
    compare("halted", halted, 1'b1);
    compare("trap", trap, exp_trap);
    if (exp_trap) begin
      compare("trap_cause", trap_cause, exp_cause);
      compare("trap_pc", trap_pc, exp_pc);
    end
    if (exp_addr.size() != 0) begin
      errors++;
      $display("%0d expected write bytes were never issued", exp_addr.size());
    end
  endtask

  task automatic alu_sequence();
    word_t a;
    word_t b;
    addr_t ea;
    begin_program();
    a = rand_bits(16);
    b = rand_bits(16);
    put_word(16'hFF80, a);
    put_word(16'hFF82, b);
    put_word(16'hFF84, 16'h4000);
    put_word(16'hFF86, 16'h0123);
    modeup(TIER_TURBO, asm_pc + 16'd7);
    // X1 a, X2 b, X3 base, X4 index
    for (int i = 1; i <= 4; i++) begin
      page1(P1_OP_LD16, xidx_t'(i), 4'd0, 4'd0, byte_t'(8'h7E + 2 * i));
    end
    for (int k = 0; k <= 4; k++) begin
      page0(P0_MAJOR_REG, 4'd5, SUB_MOV, 4'd1);
      page0(P0_MAJOR_ALU, 4'd5, 4'(k), 4'd2);
      page1(P1_OP_ST16, 4'd5, 4'd3, 4'd4, byte_t'(8'hF0 - 2 * k));
      ea = 16'h4000 + 16'h0123 + 16'hFFF0 - 16'(2 * k);
      expect_word(ea, alu_ref(alu_op_e'(k), a, b));
    end
    emit(OP_HALT);
    run_program(1'b0, '0, '0);
  endtask

  task automatic register_moves();
    word_t v1;
    word_t v2;
    begin_program();
    v1 = rand_bits(16);
    v2 = rand_bits(16);
    put_word(16'hFF80, v1);
    put_word(16'hFF82, v2);
    modeup(TIER_TURBO, asm_pc + 16'd7);
    page1(P1_OP_LD16, 4'd1, 4'd0, 4'd0, 8'h80);
    page1(P1_OP_LD16, 4'd2, 4'd0, 4'd0, 8'h82);
    page0(P0_MAJOR_REG, 4'd3, SUB_MOV, 4'd1);
    page0(P0_MAJOR_REG, 4'd1, SUB_XCHG, 4'd2);
    page0(P0_MAJOR_REG, 4'd0, SUB_MOV, 4'd1);
    for (int r = 0; r < 4; r++) begin
      page1(P1_OP_ST16, xidx_t'(r), 4'd0, 4'd0, byte_t'(8'h90 + 2 * r));
    end
    expect_word(16'hFF90, 16'h0000);
    expect_word(16'hFF92, v2);
    expect_word(16'hFF94, v1);
    expect_word(16'hFF96, v1);
    emit(OP_HALT);
    run_program(1'b0, '0, '0);
  endtask

  task automatic tier_gating();
    begin_program();
    emit(OP_NOP);
    page0(P0_MAJOR_ALU, 4'd1, ALU_ADD, 4'd2);
    run_program(1'b1, CAUSE_ILLEGAL_INSN, 16'h0001);
    begin_program();
    emit(OP_NOP);
    emit(OP_NOP);
    page1(P1_OP_LD16, 4'd1, 4'd0, 4'd0, 8'h80);
    run_program(1'b1, CAUSE_ILLEGAL_INSN, 16'h0002);
    // Unknown page prefix
    begin_program();
    emit(OP_ESCAPE);
    emit(8'h92);
    run_program(1'b1, CAUSE_ILLEGAL_INSN, 16'h0000);
  endtask

  task automatic mode_stack_ops();
    byte_t tiers [4];
    word_t v;
    tiers = '{8'd7, 8'd9, 8'd7, 8'd0};
    begin_program();
    v = rand_bits(16);
    put_word(16'hFF80, v);
    modeup(TIER_TURBO, 16'h0100);
    emit(OP_HALT);
    asm_pc = 16'h0100;
    modeup(8'd9, 16'h0200);
    // Resumes here at tier 7 after the RETMD at 0x0200
    page1(P1_OP_LD16, 4'd1, 4'd0, 4'd0, 8'h80);
    page1(P1_OP_ST16, 4'd1, 4'd0, 4'd0, 8'hA0);
    expect_word(16'hFFA0, v);
    page0(P0_MAJOR_SYS, 4'd0, SUB_RETMD, 4'd0);
    asm_pc = 16'h0200;
    page0(P0_MAJOR_SYS, 4'd0, SUB_RETMD, 4'd0);
    run_program(1'b0, '0, '0);
    compare("tier change count", 16'(tier_seen.size()), 16'd4);
    for (int i = 0; i < tier_seen.size() && i < 4; i++) begin
      compare("tier", tier_seen[i], tiers[i]);
    end

    begin_program();
    page0(P0_MAJOR_SYS, 4'd0, SUB_RETMD, 4'd0);
    run_program(1'b1, CAUSE_MODESTACK_UNDERFLOW, 16'h0000);

    begin_program();
    for (int i = 1; i <= MODESTACK_DEPTH + 1; i++) begin
      modeup(byte_t'(i), asm_pc + 16'd7);
    end
    run_program(1'b1, CAUSE_MODESTACK_OVERFLOW, 16'(7 * MODESTACK_DEPTH));
    compare("tier", tier, byte_t'(MODESTACK_DEPTH));

    // Target equal to the current tier
    begin_program();
    modeup(8'd3, asm_pc + 16'd7);
    modeup(8'd3, asm_pc + 16'd7);
    run_program(1'b1, CAUSE_MODEUP_INVALID, 16'h0007);
    compare("tier", tier, 8'd3);
  endtask

  task automatic bus_fault_load();
    begin_program();
    modeup(TIER_TURBO, asm_pc + 16'd7);
    page1(P1_OP_LD16, 4'd1, 4'd0, 4'd0, ERR_ADDR[7:0]);
    run_program(1'b1, CAUSE_BUS_FAULT, 16'h0007);
  endtask

  initial begin
    alu_sequence();
    register_moves();
    tier_gating();
    mode_stack_ops();
    bus_fault_load();
    finish_run();
  end

endmodule

//--- core/z90_core.sv
// Z90 core top level
// Sequencer, X register file, 16-bit ALU and mode stack
`timescale 1ns/1ps

module z90_core (
  input  logic            clk,
  input  logic            rst_n,
  output logic            mem_req,
  input  logic            mem_req_ready,
  output z90_pkg::addr_t  mem_addr,
  output logic            mem_we,
  output z90_pkg::byte_t  mem_wdata,
  input  logic            mem_rsp_valid,
  input  z90_pkg::byte_t  mem_rdata,
  input  logic            mem_rsp_err,
  output logic            halted,
  output logic            trap,
  output z90_pkg::cause_t trap_cause,
  output z90_pkg::addr_t  trap_pc,
  output z90_pkg::byte_t  tier
);
  import z90_pkg::*;

  xidx_t   rd_idx_a;
  xidx_t   rd_idx_b;
  word_t   rd_data_a;
  word_t   rd_data_b;
  logic    wr_en_a;
  logic    wr_en_b;
  xidx_t   wr_idx_a;
  xidx_t   wr_idx_b;
  word_t   wr_data_a;
  word_t   wr_data_b;
  alu_op_e alu_op;
  word_t   alu_a;
  word_t   alu_b;
  word_t   alu_res;
  logic    md_push;
  logic    md_pop;
  byte_t   md_target;
  addr_t   md_ret_pc;
  addr_t   md_saved_pc;
  logic    md_empty;
  logic    md_full;

  z90_sequencer u_seq (
    .clk, .rst_n,
    .mem_req, .mem_req_ready, .mem_addr, .mem_we, .mem_wdata,
    .mem_rsp_valid, .mem_rdata, .mem_rsp_err,
    .halted, .trap, .trap_cause, .trap_pc,
    .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
    .wr_en_a, .wr_en_b, .wr_idx_a, .wr_idx_b, .wr_data_a, .wr_data_b,
    .alu_op, .alu_a, .alu_b, .alu_res,
    .md_push, .md_pop, .md_target, .md_ret_pc,
    .md_tier(tier), .md_saved_pc, .md_empty, .md_full
  );

  z90_xregs u_xregs (
    .clk, .rst_n,
    .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
    .wr_en_a, .wr_en_b, .wr_idx_a, .wr_idx_b, .wr_data_a, .wr_data_b
  );

  z90_alu16 u_alu (
    .op(alu_op),
    .a(alu_a),
    .b(alu_b),
    .res(alu_res)
  );

  z90_mode_stack u_mstack (
    .clk, .rst_n,
    .push(md_push),
    .pop(md_pop),
    .target(md_target),
    .ret_pc(md_ret_pc),
    .tier(tier),
    .saved_pc(md_saved_pc),
    .empty(md_empty),
    .full(md_full)
  );

endmodule

//--- core/z90_sequencer.sv
// Z90 fetch and decode FSM
// Memory bus driver, effective address generation, trap capture
`timescale 1ns/1ps

module z90_sequencer (
  input  logic              clk,
  input  logic              rst_n,
  output logic              mem_req,
  input  logic              mem_req_ready,
  output z90_pkg::addr_t    mem_addr,
  output logic              mem_we,
  output z90_pkg::byte_t    mem_wdata,
  input  logic              mem_rsp_valid,
  input  z90_pkg::byte_t    mem_rdata,
  input  logic              mem_rsp_err,
  output logic              halted,
  output logic              trap,
  output z90_pkg::cause_t   trap_cause,
  output z90_pkg::addr_t    trap_pc,
  output z90_pkg::xidx_t    rd_idx_a,
  output z90_pkg::xidx_t    rd_idx_b,
  input  z90_pkg::word_t    rd_data_a,
  input  z90_pkg::word_t    rd_data_b,
  output logic              wr_en_a,
  output logic              wr_en_b,
  output z90_pkg::xidx_t    wr_idx_a,
  output z90_pkg::xidx_t    wr_idx_b,
  output z90_pkg::word_t    wr_data_a,
  output z90_pkg::word_t    wr_data_b,
  output z90_pkg::alu_op_e  alu_op,
  output z90_pkg::word_t    alu_a,
  output z90_pkg::word_t    alu_b,
  input  z90_pkg::word_t    alu_res,
  output logic              md_push,
  output logic              md_pop,
  output z90_pkg::byte_t    md_target,
  output z90_pkg::addr_t    md_ret_pc,
  input  z90_pkg::byte_t    md_tier,
  input  z90_pkg::addr_t    md_saved_pc,
  input  logic              md_empty,
  input  logic              md_full
);
  import z90_pkg::*;

  core_state_e state_q;
  core_state_e ret_state_q;
  addr_t       pc_q;
  addr_t       insn_pc_q;
  addr_t       ea_q;
  addr_t       bus_addr_q;
  logic        bus_we_q;
  byte_t       bus_wdata_q;
  logic [2:0]  dest_q;
  logic        fetch_q;
  word_t       st_data_q;
  // 0 opcode, 1 prefix, 2 op0, 3 op1, 4 disp or tier, 5..6 entry PC or load data
  byte_t       ib_q [7];

  logic [3:0]  major;
  logic [3:0]  sub;
  logic        is_modeop;
  logic        turbo_ok;
  logic        exc;
  cause_t      exc_cause;
  addr_t       ea_calc;

  assign major     = ib_q[2][7:4];
  assign sub       = ib_q[3][7:4];
  assign is_modeop = (major == P0_MAJOR_SYS) && (sub == SUB_MODEUP || sub == SUB_RETMD);
  assign turbo_ok  = (md_tier == TIER_TURBO);
  assign ea_calc   = rd_data_a + rd_data_b + {{8{ib_q[4][7]}}, ib_q[4]};

  assign mem_req   = (state_q == BUS_REQ);
  assign mem_addr  = bus_addr_q;
  assign mem_we    = bus_we_q;
  assign mem_wdata = bus_wdata_q;

  // Page 1 reads base and index, everything else reads rd and rs
  assign rd_idx_a  = (state_q == P1_DISPATCH) ? ib_q[3][7:4] : ib_q[2][3:0];
  assign rd_idx_b  = ib_q[3][3:0];
  assign wr_idx_a  = ib_q[2][3:0];
  assign wr_idx_b  = ib_q[3][3:0];
  assign wr_data_a = (state_q == LD16_DONE)    ? {ib_q[6], ib_q[5]} :
                     (major == P0_MAJOR_ALU)   ? alu_res : rd_data_b;
  assign wr_data_b = rd_data_a;
  assign alu_op    = alu_op_e'(sub);
  assign alu_a     = rd_data_a;
  assign alu_b     = rd_data_b;
  assign md_target = ib_q[4];
  assign md_ret_pc = pc_q;

  // ----------------------------------------
  // Dispatch strobes and trap conditions
  // ----------------------------------------
  always_comb begin
    wr_en_a   = 1'b0;
    wr_en_b   = 1'b0;
    md_push   = 1'b0;
    md_pop    = 1'b0;
    exc       = 1'b0;
    exc_cause = CAUSE_ILLEGAL_INSN;
    case (state_q)
      BUS_RSP: begin
        exc       = mem_rsp_valid && mem_rsp_err;
        exc_cause = CAUSE_BUS_FAULT;
      end
      DECODE0:   exc = !(ib_q[0] inside {OP_NOP, OP_HALT, OP_ESCAPE});
      DECODE_ED: exc = !(ib_q[1] inside {PAGE0_PREFIX, PAGE1_PREFIX});
      P0_DISPATCH: begin
        if (!is_modeop && !turbo_ok) begin
          exc = 1'b1;
        end else if (major == P0_MAJOR_REG) begin
          wr_en_a = (sub == SUB_MOV) || (sub == SUB_XCHG);
          wr_en_b = (sub == SUB_XCHG);
          exc     = !wr_en_a;
        end else if (major == P0_MAJOR_ALU) begin
          wr_en_a = (sub <= 4'(ALU_XOR));
          exc     = !wr_en_a;
        end else if (major == P0_MAJOR_SYS && sub == SUB_RETMD) begin
          md_pop    = !md_empty;
          exc       = md_empty;
          exc_cause = CAUSE_MODESTACK_UNDERFLOW;
        end else begin
          exc = !is_modeop;
        end
      end
      MODEUP_EXEC: begin
        if (ib_q[3][3:0] != 4'd0 || ib_q[4] <= md_tier) begin
          exc       = 1'b1;
          exc_cause = CAUSE_MODEUP_INVALID;
        end else begin
          md_push   = !md_full;
          exc       = md_full;
          exc_cause = CAUSE_MODESTACK_OVERFLOW;
        end
      end
      P1_DISPATCH: exc = !turbo_ok || !(major inside {P1_OP_LD16, P1_OP_ST16});
      LD16_DONE:   wr_en_a = 1'b1;
      default: ;
    endcase
  end

  task automatic issue(input addr_t addr, input logic we, input byte_t wdata,
                       input logic [2:0] dest, input logic fetch, input core_state_e next);
    bus_addr_q  <= addr;
    bus_we_q    <= we;
    bus_wdata_q <= wdata;
    dest_q      <= dest;
    fetch_q     <= fetch;
    ret_state_q <= next;
    state_q     <= BUS_REQ;
  endtask

  // ----------------------------------------
  // Sequencer FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      ret_state_q <= BOUNDARY;
      pc_q        <= '0;
      bus_addr_q  <= '0;
      bus_we_q    <= 1'b0;
      bus_wdata_q <= '0;
      dest_q      <= '0;
      fetch_q     <= 1'b0;
      halted      <= 1'b0;
      trap        <= 1'b0;
      trap_cause  <= '0;
      trap_pc     <= '0;
    end else if (exc) begin
      halted     <= 1'b1;
      trap       <= 1'b1;
      trap_cause <= exc_cause;
      trap_pc    <= insn_pc_q;
      state_q    <= BOUNDARY;
    end else begin
      case (state_q)
        RESET:    state_q <= BOUNDARY;
        BOUNDARY: if (!halted) issue(pc_q, 1'b0, '0, 3'd0, 1'b1, DECODE0);
        BUS_REQ:  if (mem_req_ready) state_q <= BUS_RSP;
        BUS_RSP: begin
          if (mem_rsp_valid) begin
            if (fetch_q) pc_q <= pc_q + 16'd1;
            state_q <= ret_state_q;
          end
        end
        DECODE0: begin
          if (ib_q[0] == OP_ESCAPE) issue(pc_q, 1'b0, '0, 3'd1, 1'b1, DECODE_ED);
          else state_q <= BOUNDARY;
          if (ib_q[0] == OP_HALT) halted <= 1'b1;
        end
        DECODE_ED: begin
          issue(pc_q, 1'b0, '0, 3'd2, 1'b1,
                (ib_q[1] == PAGE0_PREFIX) ? P0_OP1 : P1_OP1);
        end
        P0_OP1: issue(pc_q, 1'b0, '0, 3'd3, 1'b1, P0_DISPATCH);
        P0_DISPATCH: begin
          if (is_modeop && sub == SUB_MODEUP) begin
            issue(pc_q, 1'b0, '0, 3'd4, 1'b1, MODEUP_LO);
          end else begin
            if (md_pop) pc_q <= md_saved_pc;
            state_q <= BOUNDARY;
          end
        end
        MODEUP_LO: issue(pc_q, 1'b0, '0, 3'd5, 1'b1, MODEUP_HI);
        MODEUP_HI: issue(pc_q, 1'b0, '0, 3'd6, 1'b1, MODEUP_EXEC);
        MODEUP_EXEC: begin
          pc_q    <= {ib_q[6], ib_q[5]};
          state_q <= BOUNDARY;
        end
        P1_OP1:  issue(pc_q, 1'b0, '0, 3'd3, 1'b1, P1_DISP);
        P1_DISP: issue(pc_q, 1'b0, '0, 3'd4, 1'b1, P1_DISPATCH);
        P1_DISPATCH: begin
          if (major == P1_OP_LD16) issue(ea_calc, 1'b0, '0, 3'd5, 1'b0, LD16_HI);
          else issue(ea_calc, 1'b1, st_data_q[7:0], 3'd0, 1'b0, ST16_HI);
        end
        LD16_HI: issue(ea_q + 16'd1, 1'b0, '0, 3'd6, 1'b0, LD16_DONE);
        ST16_HI: issue(ea_q + 16'd1, 1'b1, st_data_q[15:8], 3'd0, 1'b0, ST16_DONE);
        default: state_q <= BOUNDARY;
      endcase
    end
  end

  // Instruction bytes, store data and effective address
  always_ff @(posedge clk) begin
    if (state_q == BOUNDARY) insn_pc_q <= pc_q;
    if (state_q == BUS_RSP && mem_rsp_valid && !bus_we_q) ib_q[dest_q] <= mem_rdata;
    if (state_q == P1_OP1) st_data_q <= rd_data_a;
    if (state_q == P1_DISPATCH) ea_q <= ea_calc;
  end

endmodule

//--- core/z90_mode_stack.sv
// Z90 mode stack
// Current tier register and saved tier / return PC entries
`timescale 1ns/1ps

module z90_mode_stack (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           push,
  input  logic           pop,
  input  z90_pkg::byte_t target,
  input  z90_pkg::addr_t ret_pc,
  output z90_pkg::byte_t tier,
  output z90_pkg::addr_t saved_pc,
  output logic           empty,
  output logic           full
);
  import z90_pkg::*;

  typedef logic [$clog2(MODESTACK_DEPTH)-1:0] slot_t;

  mdsp_t sp_q;
  slot_t top;
  byte_t tier_mem [MODESTACK_DEPTH];
  addr_t pc_mem   [MODESTACK_DEPTH];

  assign top      = slot_t'(sp_q - 1'b1);
  assign empty    = (sp_q == '0);
  assign full     = (sp_q == mdsp_t'(MODESTACK_DEPTH));
  assign saved_pc = pc_mem[top];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tier <= TIER_RESET;
      sp_q <= '0;
    end else if (push) begin
      tier <= target;
      sp_q <= sp_q + 1'b1;
    end else if (pop) begin
      tier <= tier_mem[top];
      sp_q <= sp_q - 1'b1;
    end
  end

  // Entry written at the current stack pointer
  always_ff @(posedge clk) begin
    if (push) begin
      tier_mem[slot_t'(sp_q)] <= tier;
      pc_mem[slot_t'(sp_q)]   <= ret_pc;
    end
  end

endmodule

//--- core/z90_xregs.sv
// Z90 X register file
// Sixteen 16-bit registers, two read and two write ports
// X0 reads as zero and ignores writes
`timescale 1ns/1ps

module z90_xregs (
  input  logic           clk,
  input  logic           rst_n,
  input  z90_pkg::xidx_t rd_idx_a,
  input  z90_pkg::xidx_t rd_idx_b,
  output z90_pkg::word_t rd_data_a,
  output z90_pkg::word_t rd_data_b,
  input  logic           wr_en_a,
  input  logic           wr_en_b,
  input  z90_pkg::xidx_t wr_idx_a,
  input  z90_pkg::xidx_t wr_idx_b,
  input  z90_pkg::word_t wr_data_a,
  input  z90_pkg::word_t wr_data_b
);
  import z90_pkg::*;

  word_t x_q [16];

  // Port B is applied last so it wins on a shared index
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        x_q[i] <= '0;
      end
    end else begin
      if (wr_en_a && wr_idx_a != 4'd0) begin
        x_q[wr_idx_a] <= wr_data_a;
      end
      if (wr_en_b && wr_idx_b != 4'd0) begin
        x_q[wr_idx_b] <= wr_data_b;
      end
    end
  end

  // X0 keeps its reset value
  assign rd_data_a = x_q[rd_idx_a];
  assign rd_data_b = x_q[rd_idx_b];

endmodule

//--- core/z90_alu16.sv
// Z90 page 0 ALU
// Combinational 16-bit add, subtract, and, or, xor
`timescale 1ns/1ps

module z90_alu16 (
  input  z90_pkg::alu_op_e op,
  input  z90_pkg::word_t   a,
  input  z90_pkg::word_t   b,
  output z90_pkg::word_t   res
);
  import z90_pkg::*;

  // Results wrap modulo 2^16
  always_comb begin
    case (op)
      ALU_ADD: begin
        res = a + b;
      end
      ALU_SUB: begin
        res = a - b;
      end
      ALU_AND: begin
        res = a & b;
      end
      ALU_OR: begin
        res = a | b;
      end
      ALU_XOR: begin
        res = a ^ b;
      end
      default: begin
        res = '0;
      end
    endcase
  end

endmodule

//--- common/z90_pkg.sv
// Shared Z90 definitions
// Widths and types, trap causes, tiers, mode stack depth
// Opcodes, page prefixes, major and sub codes, ALU op and FSM state enums

package z90_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [3:0]  xidx_t;
  typedef logic [7:0]  cause_t;

  // Trap causes
  localparam cause_t CAUSE_ILLEGAL_INSN        = 8'h01;
  localparam cause_t CAUSE_BUS_FAULT           = 8'h02;
  localparam cause_t CAUSE_MODESTACK_OVERFLOW  = 8'h10;
  localparam cause_t CAUSE_MODESTACK_UNDERFLOW = 8'h11;
  localparam cause_t CAUSE_MODEUP_INVALID      = 8'h12;

  localparam byte_t TIER_RESET = 8'd0;
  localparam byte_t TIER_TURBO = 8'd7;

  localparam int unsigned MODESTACK_DEPTH = 4;
  typedef logic [$clog2(MODESTACK_DEPTH + 1)-1:0] mdsp_t;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  localparam byte_t OP_NOP    = 8'h00;
  localparam byte_t OP_HALT   = 8'h76;
  localparam byte_t OP_ESCAPE = 8'hED;

  localparam byte_t PAGE0_PREFIX = 8'h90;
  localparam byte_t PAGE1_PREFIX = 8'h91;

  localparam logic [3:0] P0_MAJOR_REG = 4'd0;
  localparam logic [3:0] P0_MAJOR_ALU = 4'd1;
  localparam logic [3:0] P0_MAJOR_SYS = 4'd2;

  localparam logic [3:0] SUB_MOV    = 4'd0;
  localparam logic [3:0] SUB_XCHG   = 4'd1;
  localparam logic [3:0] SUB_MODEUP = 4'd0;
  localparam logic [3:0] SUB_RETMD  = 4'd1;

  localparam logic [3:0] P1_OP_LD16 = 4'd1;
  localparam logic [3:0] P1_OP_ST16 = 4'd2;

  // Values match the page 0 ALU sub field
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4
  } alu_op_e;

  typedef enum logic [4:0] {
    RESET, BOUNDARY, BUS_REQ, BUS_RSP,
    DECODE0, DECODE_ED,
    P0_OP1, P0_DISPATCH,
    MODEUP_LO, MODEUP_HI, MODEUP_EXEC,
    P1_OP1, P1_DISP, P1_DISPATCH,
    LD16_HI, LD16_DONE,
    ST16_HI, ST16_DONE
  } core_state_e;

endpackage
